//--- logic/speckle_pkg.sv
package speckle_pkg;

    // Sensor geometry
    localparam int ROWS    = 24;
    localparam int COLS    = 24;
    localparam int NB_DATA = 12;                   // ADC sample width
    localparam int DEPTH   = ROWS * COLS;
    localparam int NB_DIV  = 24;                   // Serial clock divider width

    typedef logic [NB_DATA-1:0]       pixel_t;
    typedef logic [$clog2(ROWS)-1:0]  row_t;
    typedef logic [$clog2(COLS)-1:0]  col_t;
    typedef logic [$clog2(DEPTH)-1:0] addr_t;      // col * ROWS + row
    typedef logic [NB_DIV-1:0]        div_t;       // Half period in system cycles

    typedef enum logic {
        MODE_SCAN   = 1'b0,
        MODE_CONFIG = 1'b1
    } mode_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        SCAN_TRIG = 3'd1,
        SCAN_WAIT = 3'd2,
        CFG_READ  = 3'd3,
        CFG_SEND  = 3'd4,
        CFG_KEY   = 3'd5,
        FINISH    = 3'd6
    } seq_state_e;

    typedef struct packed {
        logic   done;                              // Conversion finished strobe
        pixel_t value;
    } adc_rsp_t;

    // Pins of the single serial configuration chain
    typedef struct packed {
        logic sclk;
        logic sdata;
        logic key_wr;
    } chip_pins_t;

    typedef struct packed {
        logic valid;
        logic data;                                // Config bit for the chain
        logic key;                                 // Key write instead of a bit
    } shift_req_t;

endpackage

//--- logic/pixel_counter.sv
module pixel_counter (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_clear,
    input  logic               i_step,
    output speckle_pkg::addr_t o_addr,
    output logic               o_last
);

    speckle_pkg::row_t row;
    speckle_pkg::col_t col;
    logic              row_wrap;

    assign row_wrap = (row == speckle_pkg::row_t'(speckle_pkg::ROWS - 1));
    assign o_last   = row_wrap && (col == speckle_pkg::col_t'(speckle_pkg::COLS - 1));

    // Column-major linear address
    assign o_addr = speckle_pkg::addr_t'(col) * speckle_pkg::addr_t'(speckle_pkg::ROWS)
                  + speckle_pkg::addr_t'(row);

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_clear) begin
            row <= '0;
            col <= '0;
        end else if (i_step) begin
            if (row_wrap) begin
                row <= '0;
                // Carry into the column, wrap after the final pixel
                if (o_last) begin
                    col <= '0;
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                row <= row + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_addr < speckle_pkg::DEPTH);

endmodule

//--- logic/pixel_ram.sv
module pixel_ram (
    input  logic                clk,
    input  speckle_pkg::addr_t  i_addr,
    input  logic                i_we,
    input  speckle_pkg::pixel_t i_wdata,
    output speckle_pkg::pixel_t o_rdata
);

    // One full frame, maps to a block RAM
    speckle_pkg::pixel_t mem [speckle_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];                    // Read-first, one cycle latency
    end

endmodule

//--- logic/chip_shifter.sv
module chip_shifter (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  speckle_pkg::div_t       i_clk_div,
    input  speckle_pkg::shift_req_t i_req,
    output logic                    o_ready,
    output speckle_pkg::chip_pins_t o_chip
);

    logic              active;                     // Bit or key pulse in progress
    logic              second_half;
    speckle_pkg::div_t phase_cnt;
    logic              half_done;

    assign o_ready   = !active;
    assign half_done = (phase_cnt == i_clk_div);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            active      <= 1'b0;
            second_half <= 1'b0;
            phase_cnt   <= '0;
            o_chip      <= '0;
        end else if (!active) begin
            if (i_req.valid) begin
                active      <= 1'b1;
                second_half <= 1'b0;
                phase_cnt   <= speckle_pkg::div_t'(1);
                if (i_req.key) begin
                    o_chip.key_wr <= 1'b1;         // Held for both half periods
                end else begin
                    o_chip.sdata <= i_req.data;    // Stable through the whole bit
                end
            end
        end else if (half_done) begin
            phase_cnt <= speckle_pkg::div_t'(1);
            if (!second_half) begin
                second_half <= 1'b1;
                o_chip.sclk <= !o_chip.key_wr;     // Key pulse keeps clock low
            end else begin
                // End of the request, ready again next cycle
                active        <= 1'b0;
                o_chip.sclk   <= 1'b0;
                o_chip.key_wr <= 1'b0;
            end
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_chip.key_wr && o_chip.sclk));

endmodule

//--- logic/mode_sequencer.sv
module mode_sequencer (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  speckle_pkg::mode_e      i_mode,
    input  speckle_pkg::pixel_t     i_threshold,
    input  speckle_pkg::adc_rsp_t   i_adc,
    input  logic                    i_last,
    input  speckle_pkg::pixel_t     i_ram_rdata,
    input  logic                    i_shift_ready,
    output logic                    o_adc_trigger,
    output logic                    o_cnt_clear,
    output logic                    o_cnt_step,
    output logic                    o_ram_we,
    output speckle_pkg::pixel_t     o_ram_wdata,
    output speckle_pkg::shift_req_t o_shift,
    output logic                    o_busy,
    output logic                    o_done
);

    speckle_pkg::seq_state_e state;
    speckle_pkg::seq_state_e state_next;
    logic                    key_sent;             // Key request already taken
    logic                    shift_take;

    assign shift_take  = o_shift.valid && i_shift_ready;
    assign o_busy      = (state != speckle_pkg::IDLE);
    assign o_ram_wdata = i_adc.value;              // Sample goes straight to the RAM

    always_comb begin
        state_next  = state;
        o_cnt_clear = 1'b0;
        o_cnt_step  = 1'b0;
        o_ram_we    = 1'b0;
        o_shift     = '0;
        case (state)
            speckle_pkg::IDLE: begin
                if (i_start) begin
                    o_cnt_clear = 1'b1;            // Every run starts at pixel 0
                    if (i_mode == speckle_pkg::MODE_SCAN) begin
                        state_next = speckle_pkg::SCAN_TRIG;
                    end else begin
                        state_next = speckle_pkg::CFG_READ;
                    end
                end
            end
            speckle_pkg::SCAN_TRIG: begin
                state_next = speckle_pkg::SCAN_WAIT;
            end
            speckle_pkg::SCAN_WAIT: begin
                // Hold here as long as the converter is busy
                if (i_adc.done) begin
                    o_ram_we   = 1'b1;
                    o_cnt_step = 1'b1;
                    if (i_last) begin
                        state_next = speckle_pkg::FINISH;
                    end else begin
                        state_next = speckle_pkg::SCAN_TRIG;
                    end
                end
            end
            speckle_pkg::CFG_READ: begin
                state_next = speckle_pkg::CFG_SEND; // RAM output valid next cycle
            end
            speckle_pkg::CFG_SEND: begin
                o_shift.valid = 1'b1;
                o_shift.data  = (i_ram_rdata > i_threshold);
                if (i_shift_ready) begin
                    o_cnt_step = 1'b1;
                    if (i_last) begin
                        state_next = speckle_pkg::CFG_KEY;
                    end else begin
                        state_next = speckle_pkg::CFG_READ;
                    end
                end
            end
            speckle_pkg::CFG_KEY: begin
                o_shift.valid = !key_sent;
                o_shift.key   = 1'b1;
                // Shifter idle again means the key pulse is over
                if (key_sent && i_shift_ready) begin
                    state_next = speckle_pkg::FINISH;
                end
            end
            speckle_pkg::FINISH: begin
                state_next = speckle_pkg::IDLE;
            end
            default: begin
                state_next = speckle_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state         <= speckle_pkg::IDLE;
            o_adc_trigger <= 1'b0;
            o_done        <= 1'b0;
            key_sent      <= 1'b0;
        end else begin
            state         <= state_next;
            o_adc_trigger <= (state_next == speckle_pkg::SCAN_TRIG); // Pulse on entry
            o_done        <= (state == speckle_pkg::FINISH);        // Falls with o_busy
            if (state != speckle_pkg::CFG_KEY) begin
                key_sent <= 1'b0;
            end else if (shift_take) begin
                key_sent <= 1'b1;
            end
        end
    end

    // Trigger is a single-cycle pulse issued only from SCAN_TRIG
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_adc_trigger |-> ((state == speckle_pkg::SCAN_TRIG) ##1 !o_adc_trigger));

    // Pending request must not change under back-pressure
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_shift.valid && !i_shift_ready) |=> $stable(o_shift));

endmodule

//--- logic/speckle_sensor_controller.sv
module speckle_sensor_controller (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  speckle_pkg::mode_e      i_mode,
    input  speckle_pkg::pixel_t     i_threshold,
    input  speckle_pkg::div_t       i_clk_div,
    input  speckle_pkg::adc_rsp_t   i_adc,
    output logic                    o_adc_trigger,
    output speckle_pkg::chip_pins_t o_chip,
    output logic                    o_busy,
    output logic                    o_done
);

    logic                    cnt_clear;
    logic                    cnt_step;
    logic                    cnt_last;
    speckle_pkg::addr_t      ram_addr;
    logic                    ram_we;
    speckle_pkg::pixel_t     ram_wdata;
    speckle_pkg::pixel_t     ram_rdata;
    speckle_pkg::shift_req_t shift_req;
    logic                    shift_ready;

    mode_sequencer u_mode_sequencer (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_start       ( i_start       ),
        .i_mode        ( i_mode        ),
        .i_threshold   ( i_threshold   ),
        .i_adc         ( i_adc         ),
        .i_last        ( cnt_last      ),
        .i_ram_rdata   ( ram_rdata     ),
        .i_shift_ready ( shift_ready   ),
        .o_adc_trigger ( o_adc_trigger ),
        .o_cnt_clear   ( cnt_clear     ),
        .o_cnt_step    ( cnt_step      ),
        .o_ram_we      ( ram_we        ),
        .o_ram_wdata   ( ram_wdata     ),
        .o_shift       ( shift_req     ),
        .o_busy        ( o_busy        ),
        .o_done        ( o_done        )
    );

    // Shared address for both scan writes and configure reads
    pixel_counter u_pixel_counter (
        .clk     ( clk       ),
        .i_rst_n ( i_rst_n   ),
        .i_clear ( cnt_clear ),
        .i_step  ( cnt_step  ),
        .o_addr  ( ram_addr  ),
        .o_last  ( cnt_last  )
    );

    pixel_ram u_pixel_ram (
        .clk     ( clk       ),
        .i_addr  ( ram_addr  ),
        .i_we    ( ram_we    ),
        .i_wdata ( ram_wdata ),
        .o_rdata ( ram_rdata )
    );

    chip_shifter u_chip_shifter (
        .clk       ( clk         ),
        .i_rst_n   ( i_rst_n     ),
        .i_clk_div ( i_clk_div   ),
        .i_req     ( shift_req   ),
        .o_ready   ( shift_ready ),
        .o_chip    ( o_chip      )
    );

endmodule

//--- bench/tb_clock.sv
module tb_clock (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;     // 8 ns period
    end

endmodule

//--- bench/tb_speckle.sv
module tb_speckle;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUNS    = 6;
    localparam int MAX_DIV = 3;
    localparam int LIMIT   = RUNS * speckle_pkg::DEPTH * (4 * MAX_DIV + 8);

    logic                    clk;
    logic                    i_rst_n;
    logic                    i_start;
    speckle_pkg::mode_e      i_mode;
    speckle_pkg::pixel_t     i_threshold;
    speckle_pkg::div_t       i_clk_div;
    speckle_pkg::adc_rsp_t   i_adc;
    logic                    o_adc_trigger;
    speckle_pkg::chip_pins_t o_chip;
    logic                    o_busy;
    logic                    o_done;

    speckle_pkg::pixel_t model [speckle_pkg::DEPTH];  // Samples in column-major order
    logic [31:0]         rng_state = 32'd55926;
    int                  trig_cnt  = 0;
    int                  bit_cnt   = 0;
    int                  key_cnt   = 0;
    logic                reflect_on;                   // Pixel check at threshold 0 and max

    tb_clock u_clock (.o_clk(clk));

    speckle_sensor_controller i_speckle_sensor_controller (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_start       ( i_start       ),
        .i_mode        ( i_mode        ),
        .i_threshold   ( i_threshold   ),
        .i_clk_div     ( i_clk_div     ),
        .i_adc         ( i_adc         ),
        .o_adc_trigger ( o_adc_trigger ),
        .o_chip        ( o_chip        ),
        .o_busy        ( o_busy        ),
        .o_done        ( o_done        )
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_pixel(input speckle_pkg::pixel_t got, input speckle_pkg::pixel_t exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_count(input speckle_pkg::addr_t got, input speckle_pkg::addr_t exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    // One run from start to done, with a stray start while busy
    task automatic run_mode(input speckle_pkg::mode_e mode);
        int  trig_base;
        int  bit_base;
        int  key_base;
        logic scan;
        trig_base = trig_cnt;
        bit_base  = bit_cnt;
        key_base  = key_cnt;
        scan      = (mode == speckle_pkg::MODE_SCAN);
        @(posedge clk);
        #1 i_mode  = mode;
        i_start = 1'b1;
        @(posedge clk);
        #1 i_start = 1'b0;
        @(negedge clk);
        check_bit(o_busy, 1'b1, "busy after start");
        repeat (12) @(posedge clk);
        #1 i_start = 1'b1;                             // Must be ignored
        @(posedge clk);
        #1 i_start = 1'b0;
        @(negedge clk);
        while (!o_done) @(negedge clk);
        check_bit(o_busy, 1'b0, "busy in done cycle");
        check_count(speckle_pkg::addr_t'(trig_cnt - trig_base),
                    scan ? speckle_pkg::addr_t'(speckle_pkg::DEPTH) : '0, "trigger count");
        check_count(speckle_pkg::addr_t'(bit_cnt - bit_base),
                    scan ? '0 : speckle_pkg::addr_t'(speckle_pkg::DEPTH), "config bit count");
        check_count(speckle_pkg::addr_t'(key_cnt - key_base),
                    scan ? '0 : speckle_pkg::addr_t'(1), "key write count");
        @(negedge clk);
        check_bit(o_done, 1'b0, "done after one cycle");
    endtask

    task automatic run_config(input speckle_pkg::pixel_t thr, input logic reflect);
        @(posedge clk);
        #1 i_threshold = thr;
        i_clk_div  = speckle_pkg::div_t'(1 + (next_rand() % 32'd3));
        reflect_on = reflect;
        run_mode(speckle_pkg::MODE_CONFIG);
    endtask

    // ADC model, answers each trigger after a random delay
    initial begin
        int          delay;
        logic [31:0] r;
        i_adc = '0;
        forever begin
            @(negedge clk);
            if (o_adc_trigger) begin
                delay = 1 + int'(next_rand() % 32'd5);
                r     = next_rand();
                model[speckle_pkg::addr_t'(trig_cnt % speckle_pkg::DEPTH)] =
                    speckle_pkg::pixel_t'(r);
                trig_cnt++;
                repeat (delay) @(posedge clk);
                #1 i_adc.done = 1'b1;
                i_adc.value = speckle_pkg::pixel_t'(r);
                @(posedge clk);
                #1 i_adc.done = 1'b0;
            end
        end
    end

    // Serial chain monitor, data taken at each rising serial clock
    initial begin
        logic                prev_sclk;
        logic                prev_key;
        logic                exp_bit;
        speckle_pkg::addr_t  idx;
        prev_sclk = 1'b0;
        prev_key  = 1'b0;
        forever begin
            @(negedge clk);
            if (o_chip.sclk && !prev_sclk) begin
                idx     = speckle_pkg::addr_t'(bit_cnt % speckle_pkg::DEPTH);
                exp_bit = (model[idx] > i_threshold);  // Strictly greater
                if (reflect_on) begin
                    // Bit widened to a saturated pixel
                    check_pixel({speckle_pkg::NB_DATA{o_chip.sdata}},
                                {speckle_pkg::NB_DATA{exp_bit}}, "reflected pixel");
                end else begin
                    check_bit(o_chip.sdata, exp_bit, "config bit");
                end
                bit_cnt++;
            end
            if (o_chip.key_wr && !prev_key) begin
                check_count(speckle_pkg::addr_t'(bit_cnt % speckle_pkg::DEPTH), '0,
                            "bits pending at key write");
                key_cnt++;
            end
            prev_sclk = o_chip.sclk;
            prev_key  = o_chip.key_wr;
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: the runs did not finish within %0d cycles", LIMIT);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_mode      = speckle_pkg::MODE_SCAN;
        i_threshold = '0;
        i_clk_div   = speckle_pkg::div_t'(1);
        reflect_on  = 1'b0;
        repeat (8) @(posedge clk);
        #1 i_rst_n = 1'b1;
        @(negedge clk);
        check_bit(o_adc_trigger, 1'b0, "trigger after reset");
        check_bit(o_busy, 1'b0, "busy after reset");
        check_bit(o_done, 1'b0, "done after reset");
        check_bit(o_chip.sclk, 1'b0, "serial clock after reset");
        check_bit(o_chip.sdata, 1'b0, "serial data after reset");
        check_bit(o_chip.key_wr, 1'b0, "key write after reset");
        run_mode(speckle_pkg::MODE_SCAN);
        run_config(speckle_pkg::pixel_t'(next_rand()), 1'b0);
        run_mode(speckle_pkg::MODE_SCAN);           // New frame overwrites the RAM
        run_config(speckle_pkg::pixel_t'(next_rand()), 1'b0);
        run_config('0, 1'b1);
        run_config('1, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

//--- list.f
logic/speckle_pkg.sv
logic/pixel_counter.sv
logic/pixel_ram.sv
logic/chip_shifter.sv
logic/mode_sequencer.sv
logic/speckle_sensor_controller.sv
bench/tb_clock.sv
bench/tb_speckle.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the speckle controller testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_speckle -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_speckle > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
